//--- source/noc_pkg.sv
`default_nettype none

package noc_pkg;

	localparam int P = 5; // ports per router

	// router port numbering, shared by the routers and the link wiring
	typedef enum logic [2:0] {
		LOCAL = 3'd0, // core side
		EAST  = 3'd1, // x + 1
		NORTH = 3'd2, // y - 1
		WEST  = 3'd3, // x - 1
		SOUTH = 3'd4  // y + 1
	} port_e;

	typedef enum logic {
		MESH  = 1'b0,
		TORUS = 1'b1  // edges wrap around
	} topology_e;

endpackage

`default_nettype wire

//--- source/input_buffer.sv
`default_nettype none

module input_buffer #(
	parameter int NX   = 3,
	parameter int NY   = 3,
	parameter int B    = 2,
	parameter int Fpay = 32
) (
	input  wire logic          clk,
	input  wire logic          reset,
	input  wire logic          wr_i,
	input  wire logic [Fw-1:0] flit_i,
	input  wire logic          rd_i,
	output logic      [Fw-1:0] flit_o,
	output logic               not_empty_o,
	output logic               credit_o
);

	localparam int Xw   = (NX > 1) ? $clog2(NX) : 1;
	localparam int Yw   = (NY > 1) ? $clog2(NY) : 1;
	localparam int Cw   = (NX * NY > 1) ? $clog2(NX * NY) : 1;
	localparam int Fw   = Xw + Yw + Cw + Fpay;
	localparam int Aw   = (B > 1) ? $clog2(B) : 1;
	localparam int CNTw = $clog2(B + 1);

	logic [Fw-1:0]   mem [B];
	logic [Aw-1:0]   wr_ptr;
	logic [Aw-1:0]   rd_ptr;
	logic [CNTw-1:0] count; // flits held

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_i)
				wr_ptr <= (wr_ptr == Aw'(B - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_i)
				rd_ptr <= (rd_ptr == Aw'(B - 1)) ? '0 : rd_ptr + 1'b1;
			if (wr_i && !rd_i)
				count <= count + 1'b1;
			else if (!wr_i && rd_i)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_i)
			mem[wr_ptr] <= flit_i;
	end

	assign flit_o      = mem[rd_ptr]; // head flit
	assign not_empty_o = (count != '0);
	assign credit_o    = rd_i; // one slot freed per pop

endmodule

`default_nettype wire

//--- source/route_compute.sv
`default_nettype none

module route_compute #(
	parameter int                  NX       = 3,
	parameter int                  NY       = 3,
	parameter noc_pkg::topology_e  TOPOLOGY = noc_pkg::MESH,
	parameter int                  Fpay     = 32
) (
	input  wire logic [Xw-1:0] cur_x_i,
	input  wire logic [Yw-1:0] cur_y_i,
	input  wire logic [Fw-1:0] flit_i,
	output noc_pkg::port_e     out_port_o
);

	localparam int Xw = (NX > 1) ? $clog2(NX) : 1;
	localparam int Yw = (NY > 1) ? $clog2(NY) : 1;
	localparam int Cw = (NX * NY > 1) ? $clog2(NX * NY) : 1;
	localparam int Fw = Xw + Yw + Cw + Fpay;

	logic [Xw-1:0] dst_x;
	logic [Yw-1:0] dst_y;

	assign dst_x = flit_i[Fw-1 -: Xw];
	assign dst_y = flit_i[Fw-1-Xw -: Yw];

	always_comb begin
		int ex;
		int ey;
		ex = int'(dst_x) - int'(cur_x_i); // signed hop offset
		ey = int'(dst_y) - int'(cur_y_i);
		if (TOPOLOGY == noc_pkg::TORUS) begin
			// fold onto the shorter way around the ring
			ex = (ex + NX) % NX;
			ey = (ey + NY) % NY;
			if (2 * ex > NX)
				ex = ex - NX; // tie stays east
			if (2 * ey > NY)
				ey = ey - NY; // tie stays south
		end
		if (ex > 0)
			out_port_o = noc_pkg::EAST;
		else if (ex < 0)
			out_port_o = noc_pkg::WEST;
		else if (ey > 0)
			out_port_o = noc_pkg::SOUTH;
		else if (ey < 0)
			out_port_o = noc_pkg::NORTH;
		else
			out_port_o = noc_pkg::LOCAL;
	end

endmodule

`default_nettype wire

//--- source/output_arbiter.sv
`default_nettype none

module output_arbiter #(
	parameter int NX   = 3,
	parameter int NY   = 3,
	parameter int B    = 2,
	parameter int Fpay = 32
) (
	input  wire logic                      clk,
	input  wire logic                      reset,
	input  wire logic [noc_pkg::P-1:0]     req_i,
	input  wire logic [noc_pkg::P*Fw-1:0]  flit_i,
	input  wire logic                      credit_i,
	output logic      [noc_pkg::P-1:0]     grant_o,
	output logic      [Fw-1:0]             flit_o,
	output logic                           we_o
);

	localparam int Xw   = (NX > 1) ? $clog2(NX) : 1;
	localparam int Yw   = (NY > 1) ? $clog2(NY) : 1;
	localparam int Cw   = (NX * NY > 1) ? $clog2(NX * NY) : 1;
	localparam int Fw   = Xw + Yw + Cw + Fpay;
	localparam int Pw   = $clog2(noc_pkg::P);
	localparam int CNTw = $clog2(B + 1);

	logic [CNTw-1:0] credit_cnt; // free slots downstream
	logic [Pw-1:0]   last;       // last winner
	logic [Pw-1:0]   win;
	logic            send;

	// rotating priority, search starts after the last winner
	always_comb begin
		int idx;
		grant_o = '0;
		win     = last;
		send    = 1'b0;
		for (int i = 1; i <= noc_pkg::P; i++) begin
			idx = (int'(last) + i) % noc_pkg::P;
			if (!send && credit_cnt != '0 && req_i[idx]) begin
				grant_o[idx] = 1'b1;
				win          = Pw'(idx);
				send         = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			credit_cnt <= CNTw'(B);
			last       <= Pw'(noc_pkg::P - 1); // local input first
			we_o       <= 1'b0;
		end else begin
			we_o <= send;
			if (send)
				last <= win;
			if (send && !credit_i)
				credit_cnt <= credit_cnt - 1'b1;
			else if (!send && credit_i)
				credit_cnt <= credit_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (send)
			flit_o <= flit_i[int'(win)*Fw +: Fw];
	end

endmodule

`default_nettype wire

//--- source/router.sv
`default_nettype none

module router #(
	parameter int                  NX       = 3,
	parameter int                  NY       = 3,
	parameter noc_pkg::topology_e  TOPOLOGY = noc_pkg::MESH,
	parameter int                  B        = 2,
	parameter int                  Fpay     = 32
) (
	input  wire logic                      clk,
	input  wire logic                      reset,
	input  wire logic [Xw-1:0]             cur_x_i,
	input  wire logic [Yw-1:0]             cur_y_i,
	input  wire logic [noc_pkg::P*Fw-1:0]  flit_in_i,
	input  wire logic [noc_pkg::P-1:0]     flit_we_i,
	input  wire logic [noc_pkg::P-1:0]     credit_in_i,
	output logic      [noc_pkg::P*Fw-1:0]  flit_out_o,
	output logic      [noc_pkg::P-1:0]     flit_we_o,
	output logic      [noc_pkg::P-1:0]     credit_out_o
);

	localparam int Xw = (NX > 1) ? $clog2(NX) : 1;
	localparam int Yw = (NY > 1) ? $clog2(NY) : 1;
	localparam int Cw = (NX * NY > 1) ? $clog2(NX * NY) : 1;
	localparam int Fw = Xw + Yw + Cw + Fpay;
	localparam int P  = noc_pkg::P;

	logic [P*Fw-1:0] head_all;  // head flit of every input FIFO
	logic [P-1:0]    not_empty;
	logic [P-1:0]    rd;
	noc_pkg::port_e  route [P];
	logic [P-1:0]    req   [P]; // [output][input]
	logic [P-1:0]    grant [P];

	for (genvar i = 0; i < P; i++) begin : g_in
		input_buffer #(.NX(NX), .NY(NY), .B(B), .Fpay(Fpay)) u_buf (
			.clk         (clk),
			.reset       (reset),
			.wr_i        (flit_we_i[i]),
			.flit_i      (flit_in_i[i*Fw +: Fw]),
			.rd_i        (rd[i]),
			.flit_o      (head_all[i*Fw +: Fw]),
			.not_empty_o (not_empty[i]),
			.credit_o    (credit_out_o[i])
		);

		route_compute #(.NX(NX), .NY(NY), .TOPOLOGY(TOPOLOGY), .Fpay(Fpay)) u_route (
			.cur_x_i    (cur_x_i),
			.cur_y_i    (cur_y_i),
			.flit_i     (head_all[i*Fw +: Fw]),
			.out_port_o (route[i])
		);
	end

	always_comb begin
		for (int o = 0; o < P; o++) begin
			for (int i = 0; i < P; i++)
				req[o][i] = not_empty[i] && (int'(route[i]) == o);
		end
	end

	// an input pops when the output it asked for grants it
	always_comb begin
		rd = '0;
		for (int o = 0; o < P; o++) begin
			for (int i = 0; i < P; i++)
				rd[i] = rd[i] | grant[o][i];
		end
	end

	for (genvar o = 0; o < P; o++) begin : g_out
		output_arbiter #(.NX(NX), .NY(NY), .B(B), .Fpay(Fpay)) u_arb (
			.clk      (clk),
			.reset    (reset),
			.req_i    (req[o]),
			.flit_i   (head_all),
			.credit_i (credit_in_i[o]),
			.grant_o  (grant[o]),
			.flit_o   (flit_out_o[o*Fw +: Fw]),
			.we_o     (flit_we_o[o])
		);
	end

endmodule

`default_nettype wire

//--- source/noc_connection.sv
`default_nettype none

module noc_connection #(
	parameter int                  NX       = 3,
	parameter int                  NY       = 3,
	parameter noc_pkg::topology_e  TOPOLOGY = noc_pkg::MESH,
	parameter int                  Fpay     = 32
) (
	// router side, one entry per core
	input  wire logic [noc_pkg::P*Fw-1:0] router_flit_out_i   [NC],
	input  wire logic [noc_pkg::P-1:0]    router_we_out_i     [NC],
	input  wire logic [noc_pkg::P-1:0]    router_credit_out_i [NC],
	output logic      [noc_pkg::P*Fw-1:0] router_flit_in_o    [NC],
	output logic      [noc_pkg::P-1:0]    router_we_in_o      [NC],
	output logic      [noc_pkg::P-1:0]    router_credit_in_o  [NC],
	// network interface side
	input  wire logic [Fw-1:0]            ni_flit_in_i        [NC],
	input  wire logic [NC-1:0]            ni_flit_in_wr_i,
	output logic      [NC-1:0]            ni_credit_out_o,
	output logic      [Fw-1:0]            ni_flit_out_o       [NC],
	output logic      [NC-1:0]            ni_flit_out_wr_o,
	input  wire logic [NC-1:0]            ni_credit_in_i
);

	localparam int NC = NX * NY;
	localparam int Xw = (NX > 1) ? $clog2(NX) : 1;
	localparam int Yw = (NY > 1) ? $clog2(NY) : 1;
	localparam int Cw = (NC > 1) ? $clog2(NC) : 1;
	localparam int Fw = Xw + Yw + Cw + Fpay;

	localparam int LOC = int'(noc_pkg::LOCAL);
	localparam int E   = int'(noc_pkg::EAST);
	localparam int N   = int'(noc_pkg::NORTH);
	localparam int W   = int'(noc_pkg::WEST);
	localparam int S   = int'(noc_pkg::SOUTH);

	for (genvar x = 0; x < NX; x++) begin : g_x
		for (genvar y = 0; y < NY; y++) begin : g_y
			localparam int C = y * NX + x; // core number

			// input d of core C <- output OPP of the neighbour in direction d
			for (genvar d = 1; d < noc_pkg::P; d++) begin : g_dir
				localparam int OPP  = (d + 1) % 4 + 1; // E<->W, N<->S
				localparam int NBX  = (d == E) ? (x + 1) % NX :
				                      (d == W) ? (x + NX - 1) % NX : x;
				localparam int NBY  = (d == S) ? (y + 1) % NY :
				                      (d == N) ? (y + NY - 1) % NY : y;
				localparam int NB   = NBY * NX + NBX;
				localparam bit EDGE = (d == E && x == NX - 1) || (d == W && x == 0) ||
				                      (d == N && y == 0) || (d == S && y == NY - 1);

				if (EDGE && TOPOLOGY == noc_pkg::MESH) begin : g_tie
					assign router_flit_in_o[C][d*Fw +: Fw] = '0;
					assign router_we_in_o[C][d]            = 1'b0;
					assign router_credit_in_o[C][d]        = 1'b0;
				end else begin : g_link
					assign router_flit_in_o[C][d*Fw +: Fw] = router_flit_out_i[NB][OPP*Fw +: Fw];
					assign router_we_in_o[C][d]            = router_we_out_i[NB][OPP];
					assign router_credit_in_o[C][d]        = router_credit_out_i[NB][OPP];
				end
			end

			// local port to the network interface
			assign router_flit_in_o[C][LOC*Fw +: Fw] = ni_flit_in_i[C];
			assign router_we_in_o[C][LOC]            = ni_flit_in_wr_i[C];
			assign router_credit_in_o[C][LOC]        = ni_credit_in_i[C];

			assign ni_flit_out_o[C]    = router_flit_out_i[C][LOC*Fw +: Fw];
			assign ni_flit_out_wr_o[C] = router_we_out_i[C][LOC];
			assign ni_credit_out_o[C]  = router_credit_out_i[C][LOC];
		end
	end

endmodule

`default_nettype wire

//--- source/start_delay_gen.sv
`default_nettype none

module start_delay_gen #(
	parameter int NC = 9
) (
	input  wire logic          clk,
	input  wire logic          reset,
	input  wire logic          start_i,
	output logic      [NC-1:0] start_o
);

	logic [NC-1:0] stagger; // bit k fires k+1 cycles after start_i

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			stagger <= '0;
		else
			stagger <= (stagger << 1) | NC'(start_i);
	end

	assign start_o = stagger;

endmodule

`default_nettype wire

//--- source/noc_top.sv
`default_nettype none

module noc_top #(
	parameter int                  NX       = 3,
	parameter int                  NY       = 3,
	parameter noc_pkg::topology_e  TOPOLOGY = noc_pkg::MESH,
	parameter int                  B        = 2,
	parameter int                  Fpay     = 32
) (
	input  wire logic          clk,
	input  wire logic          reset,
	input  wire logic          start_i,
	output logic      [NC-1:0] start_o,
	input  wire logic [Fw-1:0] ni_flit_in_i    [NC],
	input  wire logic [NC-1:0] ni_flit_in_wr_i,
	output logic      [NC-1:0] ni_credit_out_o,
	output logic      [Fw-1:0] ni_flit_out_o   [NC],
	output logic      [NC-1:0] ni_flit_out_wr_o,
	input  wire logic [NC-1:0] ni_credit_in_i
);

	localparam int NC = NX * NY;
	localparam int Xw = (NX > 1) ? $clog2(NX) : 1;
	localparam int Yw = (NY > 1) ? $clog2(NY) : 1;
	localparam int Cw = (NC > 1) ? $clog2(NC) : 1;
	localparam int Fw = Xw + Yw + Cw + Fpay;
	localparam int P  = noc_pkg::P;

	logic [P*Fw-1:0] r_flit_out   [NC];
	logic [P-1:0]    r_we_out     [NC];
	logic [P-1:0]    r_credit_out [NC];
	logic [P*Fw-1:0] r_flit_in    [NC];
	logic [P-1:0]    r_we_in      [NC];
	logic [P-1:0]    r_credit_in  [NC];

	for (genvar x = 0; x < NX; x++) begin : g_x
		for (genvar y = 0; y < NY; y++) begin : g_y
			router #(
				.NX(NX), .NY(NY), .TOPOLOGY(TOPOLOGY), .B(B), .Fpay(Fpay)
			) u_router (
				.clk          (clk),
				.reset        (reset),
				.cur_x_i      (Xw'(x)),
				.cur_y_i      (Yw'(y)),
				.flit_in_i    (r_flit_in[y*NX+x]),
				.flit_we_i    (r_we_in[y*NX+x]),
				.credit_in_i  (r_credit_in[y*NX+x]),
				.flit_out_o   (r_flit_out[y*NX+x]),
				.flit_we_o    (r_we_out[y*NX+x]),
				.credit_out_o (r_credit_out[y*NX+x])
			);
		end
	end

	noc_connection #(.NX(NX), .NY(NY), .TOPOLOGY(TOPOLOGY), .Fpay(Fpay)) u_conn (
		.router_flit_out_i   (r_flit_out),
		.router_we_out_i     (r_we_out),
		.router_credit_out_i (r_credit_out),
		.router_flit_in_o    (r_flit_in),
		.router_we_in_o      (r_we_in),
		.router_credit_in_o  (r_credit_in),
		.ni_flit_in_i        (ni_flit_in_i),
		.ni_flit_in_wr_i     (ni_flit_in_wr_i),
		.ni_credit_out_o     (ni_credit_out_o),
		.ni_flit_out_o       (ni_flit_out_o),
		.ni_flit_out_wr_o    (ni_flit_out_wr_o),
		.ni_credit_in_i      (ni_credit_in_i)
	);

	start_delay_gen #(.NC(NC)) u_start (
		.clk     (clk),
		.reset   (reset),
		.start_i (start_i),
		.start_o (start_o)
	);

endmodule

`default_nettype wire

//--- dv/noc_assert.sv
`default_nettype none

module noc_assert #(
	parameter int B = 2
) (
	input wire logic                  clk,
	input wire logic                  reset,
	input wire logic [noc_pkg::P-1:0] in_we_i,      // flit written into an input FIFO
	input wire logic [noc_pkg::P-1:0] in_pop_i,     // credit pulse of that FIFO
	input wire logic [noc_pkg::P-1:0] out_we_i,     // flit sent downstream
	input wire logic [noc_pkg::P-1:0] out_credit_i  // credit back from downstream
);
	timeunit 1ns;
	timeprecision 100ps;

	int occ   [noc_pkg::P]; // input FIFO fill
	int avail [noc_pkg::P]; // free downstream slots per output

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int p = 0; p < noc_pkg::P; p++) begin
				occ[p]   <= 0;
				avail[p] <= B;
			end
		end else begin
			for (int p = 0; p < noc_pkg::P; p++) begin
				occ[p]   <= occ[p] + int'(in_we_i[p]) - int'(in_pop_i[p]);
				avail[p] <= avail[p] - int'(out_we_i[p]) + int'(out_credit_i[p]);
			end
		end
	end

	for (genvar p = 0; p < noc_pkg::P; p++) begin : g_port
		a_send_needs_credit: assert property (@(posedge clk) disable iff (reset)
			out_we_i[p] |-> avail[p] > 0)
			else $error("output %0d sent a flit with no credit left", p);
		a_credit_bound: assert property (@(posedge clk) disable iff (reset) avail[p] <= B)
			else $error("output %0d holds more than %0d credits", p, B);
		a_no_overflow: assert property (@(posedge clk) disable iff (reset)
			in_we_i[p] |-> occ[p] < B)
			else $error("input %0d written while its FIFO is full", p);
	end

endmodule

bind router noc_assert #(.B(B)) u_assert (
	.clk          (clk),
	.reset        (reset),
	.in_we_i      (flit_we_i),
	.in_pop_i     (credit_out_o),
	.out_we_i     (flit_we_o),
	.out_credit_i (credit_in_i)
);

`default_nettype wire

//--- dv/noc_tb.sv
`default_nettype none

module noc_tb #(
	parameter int TOPO = 0 // 0 mesh, 1 torus
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam noc_pkg::topology_e TOPOLOGY = noc_pkg::topology_e'(TOPO);
	localparam int NX = 3;
	localparam int NY = 3;
	localparam int NC = NX * NY;
	localparam int B = 2;
	localparam int Fpay = 32;
	localparam int Xw = $clog2(NX);
	localparam int Yw = $clog2(NY);
	localparam int Cw = $clog2(NC);
	localparam int Fw = Xw + Yw + Cw + Fpay;
	localparam int CLK_PERIOD = 40;
	localparam int MAXOUT = 8; // flits in flight at most
	localparam int TBL_N = 17;
	localparam int N_RAND = 10;
	localparam int WD_CYCLES = (TBL_N + N_RAND) * 50 + 200;

	typedef struct packed {
		logic [3:0]  src;
		logic [3:0]  dst;
		logic [31:0] pay;
		logic        stall; // destination holds its credits
	} entry_t;

	localparam entry_t TBL [TBL_N] = '{
		'{4'd0, 4'd4, 32'h0a00_0001, 1'b1},
		'{4'd0, 4'd4, 32'h0a00_0002, 1'b1},
		'{4'd8, 4'd4, 32'h0a00_0003, 1'b1},
		'{4'd0, 4'd2, 32'h5150_0001, 1'b0}, // west wrap on torus
		'{4'd0, 4'd2, 32'h5150_0002, 1'b0},
		'{4'd0, 4'd6, 32'h5150_0003, 1'b0}, // north wrap
		'{4'd2, 4'd0, 32'h5150_0004, 1'b0},
		'{4'd8, 4'd0, 32'h5150_0005, 1'b0},
		'{4'd5, 4'd5, 32'h5150_0006, 1'b0}, // local turnaround
		'{4'd1, 4'd0, 32'hc0de_0001, 1'b0}, // everyone to core 0
		'{4'd2, 4'd0, 32'hc0de_0002, 1'b0},
		'{4'd3, 4'd0, 32'hc0de_0003, 1'b0},
		'{4'd4, 4'd0, 32'hc0de_0004, 1'b0},
		'{4'd5, 4'd0, 32'hc0de_0005, 1'b0},
		'{4'd6, 4'd0, 32'hc0de_0006, 1'b0},
		'{4'd7, 4'd0, 32'hc0de_0007, 1'b0},
		'{4'd8, 4'd0, 32'hc0de_0008, 1'b0}
	};

	logic          clk;
	logic          reset;
	logic          start_i;
	logic [NC-1:0] start_o;
	logic [Fw-1:0] ni_flit_in [NC];
	logic [NC-1:0] ni_flit_in_wr;
	logic [NC-1:0] ni_credit_out;
	logic [Fw-1:0] ni_flit_out [NC];
	logic [NC-1:0] ni_flit_out_wr;
	logic [NC-1:0] ni_credit_in;

	logic [Fw-1:0] txq  [NC][$]; // waiting at each source
	logic [Fw-1:0] expq [NC][$]; // expected at each destination
	int            sent       [NC];
	int            cred_total [NC]; // credit pulses from the local input
	int            rcvd       [NC];
	int            ret        [NC]; // credits handed back
	logic [NC-1:0] hold;
	int            injected;
	int            arrived;
	int            val_errs;
	int            other_errs;
	logic [31:0]   lfsr;

	noc_top #(.NX(NX), .NY(NY), .TOPOLOGY(TOPOLOGY), .B(B), .Fpay(Fpay)) UUT (
		.clk              (clk),
		.reset            (reset),
		.start_i          (start_i),
		.start_o          (start_o),
		.ni_flit_in_i     (ni_flit_in),
		.ni_flit_in_wr_i  (ni_flit_in_wr),
		.ni_credit_out_o  (ni_credit_out),
		.ni_flit_out_o    (ni_flit_out),
		.ni_flit_out_wr_o (ni_flit_out_wr),
		.ni_credit_in_i   (ni_credit_in)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32 22 2 1
			lfsr = {lfsr[30:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [Fw-1:0] make_flit(input int src, input int dst,
			input logic [31:0] pay);
		return {Xw'(dst % NX), Yw'(dst / NX), Cw'(src), pay};
	endfunction

	function automatic bit drained();
		for (int c = 0; c < NC; c++)
			if (txq[c].size() != 0 || expq[c].size() != 0)
				return 1'b0;
		return 1'b1;
	endfunction

	// first expected flit from the same source must be this one
	task automatic check_arrival(input int c, input logic [Fw-1:0] f);
		int idx;
		idx = -1;
		for (int i = 0; i < expq[c].size(); i++)
			if (idx < 0 && expq[c][i][Fpay +: Cw] == f[Fpay +: Cw])
				idx = i;
		if (idx < 0) begin
			$display("core %0d received a flit it was not owed: %h", c, f);
			other_errs++;
		end else begin
			if (expq[c][idx] != f) begin
				$display("** Error at %0t: core %0d got %h, expected %h", $time, c, f,
					expq[c][idx]);
				val_errs++;
			end
			expq[c].delete(idx);
		end
	endtask

	task automatic check_start();
		logic [NC-1:0] want;
		@(posedge clk);
		start_i <= 1'b1;
		@(posedge clk);
		start_i <= 1'b0;
		for (int j = 1; j <= NC + 2; j++) begin
			@(negedge clk);
			want = (j <= NC) ? NC'(1) << (j - 1) : '0;
			if (start_o !== want) begin
				$display("** Error at %0t: start_o %b, expected %b", $time, start_o, want);
				val_errs++;
			end
		end
	endtask

	task automatic release_stall(input int dst, input int base);
		while (rcvd[dst] - base < B)
			@(posedge clk);
		repeat (20) @(posedge clk); // give extra flits time to show up
		if (rcvd[dst] - base > B) begin
			$display("** Error at %0t: core %0d took %0d flits without credits", $time, dst,
				rcvd[dst] - base);
			val_errs++;
		end
		@(negedge clk);
		hold[dst] = 1'b0;
	endtask

	always @(negedge clk) begin
		if (!reset) begin
			for (int c = 0; c < NC; c++) begin
				if (ni_credit_out[c])
					cred_total[c]++;
				if (ni_flit_out_wr[c]) begin
					check_arrival(c, ni_flit_out[c]);
					rcvd[c]++;
					arrived++;
				end
			end
		end
	end

	// interface models, inject and return credits
	always @(posedge clk) begin
		logic [NC-1:0] wr;
		logic [NC-1:0] crd;
		logic [Fw-1:0] f;
		int            dst;
		wr  = '0;
		crd = '0;
		if (!reset) begin
			for (int c = 0; c < NC; c++) begin
				if (txq[c].size() > 0 && B - sent[c] + cred_total[c] > 0 &&
						injected - arrived < MAXOUT) begin
					f   = txq[c].pop_front();
					dst = int'(f[Fw-Xw-1 -: Yw]) * NX + int'(f[Fw-1 -: Xw]);
					expq[dst].push_back(f);
					ni_flit_in[c] <= f;
					wr[c] = 1'b1;
					sent[c]++;
					injected++;
				end
				if (!hold[c] && ret[c] < rcvd[c]) begin
					crd[c] = 1'b1;
					ret[c]++;
				end
			end
		end
		ni_flit_in_wr <= wr;
		ni_credit_in  <= crd;
	end

	initial begin
		int          src;
		int          dst;
		int          base;
		logic [31:0] pay;
		reset         = 1'b1;
		start_i       = 1'b0;
		ni_flit_in_wr = '0;
		ni_credit_in  = '0;
		hold          = '0;
		lfsr          = 32'h9cd708fa;
		injected      = 0;
		arrived       = 0;
		val_errs      = 0;
		other_errs    = 0;
		base          = 0;
		for (int c = 0; c < NC; c++) begin
			ni_flit_in[c] = '0;
			sent[c]       = 0;
			cred_total[c] = 0;
			rcvd[c]       = 0;
			ret[c]        = 0;
		end
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (ni_flit_out_wr !== '0 || ni_credit_out !== '0 || start_o !== '0) begin
			$display("** Error at %0t: after reset flit_out_wr %b credit_out %b start_o %b",
				$time, ni_flit_out_wr, ni_credit_out, start_o);
			val_errs++;
		end
		check_start();
		for (int i = 0; i < TBL_N; i++) begin
			if (TBL[i].stall && !hold[TBL[i].dst]) begin
				hold[TBL[i].dst] = 1'b1;
				base = rcvd[TBL[i].dst];
			end
			txq[TBL[i].src].push_back(make_flit(TBL[i].src, TBL[i].dst, TBL[i].pay));
			if (TBL[i].stall && (i == TBL_N - 1 || !TBL[i + 1].stall))
				release_stall(TBL[i].dst, base);
		end
		for (int i = 0; i < N_RAND; i++) begin
			src = int'(take_bits(4)) % NC;
			dst = int'(take_bits(4)) % NC;
			pay = take_bits(32);
			txq[src].push_back(make_flit(src, dst, pay));
		end
		while (!drained())
			@(posedge clk);
		repeat (5) @(posedge clk);
		for (int c = 0; c < NC; c++) begin
			if (cred_total[c] != sent[c]) begin
				$display("** Error at %0t: core %0d saw %0d credits for %0d flits", $time, c,
					cred_total[c], sent[c]);
				val_errs++;
			end
		end
		$display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("timeout: traffic did not drain within %0d cycles", WD_CYCLES);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
source/noc_pkg.sv
source/input_buffer.sv
source/route_compute.sv
source/output_arbiter.sv
source/router.sv
source/noc_connection.sv
source/start_delay_gen.sv
source/noc_top.sv
dv/noc_assert.sv
dv/noc_tb.sv

//--- run_sim.sh
#!/bin/bash
# one Verilator build and run per topology, then the logs are searched for the fail message
rm -rf obj_mesh obj_torus mesh.log torus.log
{ verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module noc_tb \
	-GTOPO=0 --Mdir obj_mesh -o noc_sim && ./obj_mesh/noc_sim; } > mesh.log 2>&1 \
	|| echo "sim failed" >> mesh.log
{ verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module noc_tb \
	-GTOPO=1 --Mdir obj_torus -o noc_sim && ./obj_torus/noc_sim; } > torus.log 2>&1 \
	|| echo "sim failed" >> torus.log
grep -q "sim failed" mesh.log torus.log && { echo "FAIL: see mesh.log and torus.log"; exit 1; } \
	|| { echo "PASS: mesh and torus"; exit 0; }
